/* hw/eth_frame_macros.svh */
`ifndef ETH_FRAME_MACROS_SVH
`define ETH_FRAME_MACROS_SVH

// Payload buffer depth in bytes
`define ETH_PAYLOAD_MAX 1500

// Short payloads are padded up to this
`define ETH_PAYLOAD_MIN 46

`define ETH_FILL_BYTE 8'h55  // Fixed pattern mode payload

// Frame start
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hD5

`endif

/* hw/eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

    // One byte on the stream or in the payload buffer
    typedef logic [7:0] byte_t;

    // Station address, sent most significant byte first
    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] len_t;  // Length/type field and byte counts

    // Payload buffer address, covers 1500 entries
    typedef logic [10:0] buf_addr_t;

    // CRC register and FCS word
    typedef logic [31:0] crc_t;

endpackage

`default_nettype wire

/* hw/eth_ctrl_pkg.sv */
`default_nettype none

package eth_ctrl_pkg;

    // Payload generation modes
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,  // Buffer bytes, padded
        MODE_FIXED  = 2'd1,  // Fill pattern, padded
        MODE_NO_PAD = 2'd2   // Buffer bytes, exact length
    } gen_mode_t;

    // Frame generator FSM
    typedef enum logic [3:0] {
        ST_IDLE, ST_PREAMBLE, ST_SFD, ST_DEST, ST_SRC,
        ST_LEN, ST_PAYLOAD, ST_FCS, ST_DONE
    } gen_state_t;

endpackage

`default_nettype wire

/* hw/crc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface crc_if;

    logic                 init;  // Restart accumulator
    logic                 en;    // Fold data this cycle
    eth_frame_pkg::byte_t data;
    eth_frame_pkg::crc_t  crc;   // Complemented, ready to send

    // Generator side
    modport gen (output init, output en, output data, input crc);

    // CRC engine side
    modport eng (input init, input en, input data, output crc);

endinterface

`default_nettype wire

/* hw/crc32_byte.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_byte (
    input  wire logic clk,
    input  wire logic i_rst_n,
    crc_if.eng        crc_bus
);

    // Reflected form of 0x04C11DB7
    localparam eth_frame_pkg::crc_t CRC_POLY = 32'hEDB88320;

    eth_frame_pkg::crc_t crc_q;

    // One byte, LSB first, eight shift-and-xor steps
    function automatic eth_frame_pkg::crc_t crc_fold(
        input eth_frame_pkg::crc_t  crc_in,
        input eth_frame_pkg::byte_t data_in
    );
        eth_frame_pkg::crc_t c;
        c = crc_in ^ {24'h000000, data_in};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= '1;
        end else if (crc_bus.init) begin
            crc_q <= '1;  // All-ones seed
        end else if (crc_bus.en) begin
            crc_q <= crc_fold(crc_q, crc_bus.data);
        end
    end

    assign crc_bus.crc = ~crc_q;  // Final complement

endmodule

`default_nettype wire

/* hw/payload_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_frame_macros.svh"

module payload_buffer (
    input  wire logic                      clk,
    input  wire logic                      i_wr_en,
    input  wire eth_frame_pkg::buf_addr_t  i_wr_addr,
    input  wire eth_frame_pkg::byte_t      i_wr_data,
    input  wire eth_frame_pkg::buf_addr_t  i_rd_addr,
    output eth_frame_pkg::byte_t           o_rd_data
);

    eth_frame_pkg::byte_t mem [`ETH_PAYLOAD_MAX];

    // Host write port
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* hw/mac_frame_generator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_frame_macros.svh"

module mac_frame_generator (
    input  wire logic                      clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_start,
    input  wire eth_frame_pkg::mac_addr_t  i_dest_addr,
    input  wire eth_frame_pkg::mac_addr_t  i_src_addr,
    input  wire eth_frame_pkg::len_t       i_length,
    input  wire eth_ctrl_pkg::gen_mode_t   i_mode,
    input  wire eth_frame_pkg::byte_t      i_rd_data,
    output eth_frame_pkg::buf_addr_t       o_rd_addr,
    output eth_frame_pkg::byte_t           o_tx_data,
    output logic                           o_tx_valid,
    output logic                           o_tx_last,
    output logic                           o_busy,
    output logic                           o_done,
    crc_if.gen                             crc_bus
);

    eth_ctrl_pkg::gen_state_t state_q, state_d;
    eth_frame_pkg::len_t      cnt_q, cnt_d;     // Byte index within field

    // Frame fields, held for the whole frame
    eth_frame_pkg::mac_addr_t dest_q, src_q;
    eth_frame_pkg::len_t      len_q;
    eth_frame_pkg::len_t      pay_cnt_q;        // Padded payload count
    eth_ctrl_pkg::gen_mode_t  mode_q;
    eth_frame_pkg::crc_t      fcs_q;

    logic                     start_ok;
    logic [2:0]               byte_sel;
    eth_frame_pkg::len_t      rd_next;
    eth_frame_pkg::byte_t     payload_byte;
    eth_frame_pkg::crc_t      fcs_word;
    eth_frame_pkg::byte_t     tx_data;

    assign start_ok = (state_q == eth_ctrl_pkg::ST_IDLE) && i_start;
    assign byte_sel = cnt_q[2:0];

    always_ff @(posedge clk) begin
        if (start_ok) begin
            dest_q <= i_dest_addr;
            src_q  <= i_src_addr;
            len_q  <= i_length;
            mode_q <= i_mode;
            // Pad short frames unless padding is off
            if (i_length < `ETH_PAYLOAD_MIN && i_mode != eth_ctrl_pkg::MODE_NO_PAD)
                pay_cnt_q <= eth_frame_pkg::len_t'(`ETH_PAYLOAD_MIN);
            else
                pay_cnt_q <= i_length;
        end
        // CRC engine output settles in the first FCS cycle
        if (state_q == eth_ctrl_pkg::ST_FCS && cnt_q == '0) begin
            fcs_q <= crc_bus.crc;
        end
    end

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q + 16'd1;
        case (state_q)
            eth_ctrl_pkg::ST_IDLE: begin
                cnt_d = '0;
                if (i_start) state_d = eth_ctrl_pkg::ST_PREAMBLE;
            end
            eth_ctrl_pkg::ST_PREAMBLE: begin
                if (cnt_q == 16'd6) begin
                    state_d = eth_ctrl_pkg::ST_SFD;
                    cnt_d   = '0;
                end
            end
            eth_ctrl_pkg::ST_SFD: begin
                state_d = eth_ctrl_pkg::ST_DEST;
                cnt_d   = '0;
            end
            eth_ctrl_pkg::ST_DEST: begin
                if (cnt_q == 16'd5) begin
                    state_d = eth_ctrl_pkg::ST_SRC;
                    cnt_d   = '0;
                end
            end
            eth_ctrl_pkg::ST_SRC: begin
                if (cnt_q == 16'd5) begin
                    state_d = eth_ctrl_pkg::ST_LEN;
                    cnt_d   = '0;
                end
            end
            eth_ctrl_pkg::ST_LEN: begin
                if (cnt_q == 16'd1) begin
                    cnt_d = '0;
                    // Zero-length frames go straight to the FCS
                    state_d = (pay_cnt_q == '0) ? eth_ctrl_pkg::ST_FCS
                                                : eth_ctrl_pkg::ST_PAYLOAD;
                end
            end
            eth_ctrl_pkg::ST_PAYLOAD: begin
                if (cnt_q == pay_cnt_q - 16'd1) begin
                    state_d = eth_ctrl_pkg::ST_FCS;
                    cnt_d   = '0;
                end
            end
            eth_ctrl_pkg::ST_FCS: begin
                if (cnt_q == 16'd3) state_d = eth_ctrl_pkg::ST_DONE;
            end
            default: begin  // ST_DONE
                state_d = eth_ctrl_pkg::ST_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= eth_ctrl_pkg::ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // Address one byte ahead; address 0 goes out in the last length cycle
    assign rd_next   = cnt_q + 16'd1;
    assign o_rd_addr = (state_q == eth_ctrl_pkg::ST_PAYLOAD) ?
                       eth_frame_pkg::buf_addr_t'(rd_next) : '0;

    always_comb begin
        if (cnt_q >= len_q)
            payload_byte = 8'h00;  // Pad
        else if (mode_q == eth_ctrl_pkg::MODE_FIXED)
            payload_byte = `ETH_FILL_BYTE;
        else
            payload_byte = i_rd_data;
    end

    // First FCS byte straight from the engine, the rest from the copy
    assign fcs_word = (cnt_q == '0) ? crc_bus.crc : fcs_q;

    always_comb begin
        case (state_q)
            eth_ctrl_pkg::ST_PREAMBLE: tx_data = `ETH_PREAMBLE_BYTE;
            eth_ctrl_pkg::ST_SFD:      tx_data = `ETH_SFD_BYTE;
            eth_ctrl_pkg::ST_DEST:     tx_data = dest_q[47 - 8*byte_sel -: 8];
            eth_ctrl_pkg::ST_SRC:      tx_data = src_q[47 - 8*byte_sel -: 8];
            eth_ctrl_pkg::ST_LEN:      tx_data = cnt_q[0] ? len_q[7:0] : len_q[15:8];
            eth_ctrl_pkg::ST_PAYLOAD:  tx_data = payload_byte;
            eth_ctrl_pkg::ST_FCS:      tx_data = fcs_word[8*cnt_q[1:0] +: 8];  // Low byte first
            default:                   tx_data = 8'h00;
        endcase
    end

    // CRC covers destination through last payload byte
    assign crc_bus.init = (state_q == eth_ctrl_pkg::ST_SFD);
    assign crc_bus.en   = (state_q == eth_ctrl_pkg::ST_DEST) ||
                          (state_q == eth_ctrl_pkg::ST_SRC) ||
                          (state_q == eth_ctrl_pkg::ST_LEN) ||
                          (state_q == eth_ctrl_pkg::ST_PAYLOAD);
    assign crc_bus.data = tx_data;

    assign o_tx_data  = tx_data;
    assign o_tx_valid = (state_q != eth_ctrl_pkg::ST_IDLE) &&
                        (state_q != eth_ctrl_pkg::ST_DONE);
    assign o_tx_last  = (state_q == eth_ctrl_pkg::ST_FCS) && (cnt_q == 16'd3);
    assign o_done     = (state_q == eth_ctrl_pkg::ST_DONE);
    assign o_busy     = (state_q != eth_ctrl_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hw/mac_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_tx_top (
    input  wire logic                      clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_wr_en,
    input  wire eth_frame_pkg::buf_addr_t  i_wr_addr,
    input  wire eth_frame_pkg::byte_t      i_wr_data,
    input  wire logic                      i_start,
    input  wire eth_frame_pkg::mac_addr_t  i_dest_addr,
    input  wire eth_frame_pkg::mac_addr_t  i_src_addr,
    input  wire eth_frame_pkg::len_t       i_length,
    input  wire eth_ctrl_pkg::gen_mode_t   i_mode,
    output eth_frame_pkg::byte_t           o_tx_data,
    output logic                           o_tx_valid,
    output logic                           o_tx_last,
    output logic                           o_busy,
    output logic                           o_done
);

    eth_frame_pkg::buf_addr_t rd_addr;
    eth_frame_pkg::byte_t     rd_data;

    crc_if crc_bus ();

    payload_buffer payload_buffer_inst (
        .clk       (clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    mac_frame_generator mac_frame_generator_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_dest_addr (i_dest_addr),
        .i_src_addr  (i_src_addr),
        .i_length    (i_length),
        .i_mode      (i_mode),
        .i_rd_data   (rd_data),
        .o_rd_addr   (rd_addr),
        .o_tx_data   (o_tx_data),
        .o_tx_valid  (o_tx_valid),
        .o_tx_last   (o_tx_last),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .crc_bus     (crc_bus.gen)
    );

    crc32_byte crc32_byte_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .crc_bus (crc_bus.eng)
    );

endmodule

`default_nettype wire

/* bench/tb_frame_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_frame_macros.svh"

module tb_frame_checker (
    input  wire logic                      clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_wr_en,
    input  wire eth_frame_pkg::buf_addr_t  i_wr_addr,
    input  wire eth_frame_pkg::byte_t      i_wr_data,
    input  wire logic                      i_start,
    input  wire eth_frame_pkg::mac_addr_t  i_dest_addr,
    input  wire eth_frame_pkg::mac_addr_t  i_src_addr,
    input  wire eth_frame_pkg::len_t       i_length,
    input  wire eth_ctrl_pkg::gen_mode_t   i_mode,
    input  wire eth_frame_pkg::byte_t      i_tx_data,
    input  wire logic                      i_tx_valid,
    input  wire logic                      i_tx_last,
    input  wire logic                      i_busy,
    input  wire logic                      i_done,
    output int                             o_error_count,
    output int                             o_frame_count
);

    eth_frame_pkg::byte_t shadow [`ETH_PAYLOAD_MAX];  // Copy of the host writes
    eth_frame_pkg::byte_t exp_q [$];                  // Whole expected frame
    int   errors = 0;
    int   frames = 0;
    int   pos = 0;
    logic frame_open = 1'b0;
    logic done_due = 1'b0;
    logic last_exp;

    assign o_error_count = errors;
    assign o_frame_count = frames;

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    // Bit-serial CRC-32 over data bits taken LSB first
    function automatic eth_frame_pkg::crc_t crc_serial(
        input eth_frame_pkg::crc_t  crc_in,
        input eth_frame_pkg::byte_t b
    );
        eth_frame_pkg::crc_t c;
        logic fb;
        c = crc_in;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];
            c = {1'b0, c[31:1]};
            if (fb)
                c = c ^ 32'hEDB88320;
        end
        return c;
    endfunction

    task automatic build_expected(
        input eth_frame_pkg::mac_addr_t dest,
        input eth_frame_pkg::mac_addr_t src,
        input eth_frame_pkg::len_t      len,
        input eth_ctrl_pkg::gen_mode_t  mode
    );
        eth_frame_pkg::byte_t body [$];
        eth_frame_pkg::byte_t b;
        eth_frame_pkg::crc_t  crc;
        int pay;
        exp_q.delete();
        for (int i = 0; i < 7; i++)
            exp_q.push_back(`ETH_PREAMBLE_BYTE);
        exp_q.push_back(`ETH_SFD_BYTE);
        for (int i = 0; i < 6; i++)
            body.push_back(dest[8*(5-i) +: 8]);  // MSB first on the wire
        for (int i = 0; i < 6; i++)
            body.push_back(src[8*(5-i) +: 8]);
        body.push_back(len[15:8]);
        body.push_back(len[7:0]);
        pay = int'(len);
        if (pay < `ETH_PAYLOAD_MIN && mode != eth_ctrl_pkg::MODE_NO_PAD)
            pay = `ETH_PAYLOAD_MIN;
        for (int i = 0; i < pay; i++) begin
            if (i >= int'(len))
                b = 8'h00;  // Pad
            else if (mode == eth_ctrl_pkg::MODE_FIXED)
                b = `ETH_FILL_BYTE;
            else
                b = shadow[i];
            body.push_back(b);
        end
        crc = '1;
        for (int i = 0; i < body.size(); i++) begin
            crc = crc_serial(crc, body[i]);
            exp_q.push_back(body[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            exp_q.push_back(crc[8*i +: 8]);  // FCS low byte first
    endtask

    always @(posedge clk) begin
        if (!i_rst_n) begin
            if (i_tx_valid !== 1'b0 || i_tx_last !== 1'b0 || i_busy !== 1'b0 || i_done !== 1'b0)
                report_mismatch("outputs not low during reset");
            frame_open = 1'b0;
            done_due   = 1'b0;
        end else begin
            if (i_wr_en === 1'b1)
                shadow[i_wr_addr] = i_wr_data;
            if (i_busy !== (frame_open || done_due))
                report_mismatch($sformatf("busy is %b", i_busy));
            if (i_done !== done_due)
                report_mismatch($sformatf("done is %b, expected %b", i_done, done_due));
            done_due = 1'b0;
            if (frame_open) begin
                if (i_tx_valid !== 1'b1) begin
                    report_mismatch($sformatf("valid low at byte %0d of %0d", pos, exp_q.size()));
                    frame_open = 1'b0;
                end else begin
                    last_exp = (pos == exp_q.size() - 1);
                    if (i_tx_data !== exp_q[pos])
                        report_mismatch($sformatf("byte %0d is %02h, expected %02h",
                                                  pos, i_tx_data, exp_q[pos]));
                    if (i_tx_last !== last_exp)
                        report_mismatch($sformatf("last is %b at byte %0d", i_tx_last, pos));
                    pos++;
                    if (pos == exp_q.size()) begin
                        frame_open = 1'b0;
                        done_due   = 1'b1;
                        frames++;
                    end
                end
            end else if (i_tx_valid !== 1'b0 || i_tx_last !== 1'b0) begin
                report_mismatch("valid or last outside a frame");
            end
            // Start only counts when the DUT is idle
            if (i_start === 1'b1 && i_busy === 1'b0) begin
                build_expected(i_dest_addr, i_src_addr, i_length, i_mode);
                frame_open = 1'b1;
                pos        = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_mac_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mac_tx;

    localparam int NUM_ROWS     = 6;
    localparam int DONE_TIMEOUT = 400;  // Longest frame is 126 cycles

    typedef struct packed {
        eth_frame_pkg::mac_addr_t dest;
        eth_frame_pkg::mac_addr_t src;
        eth_frame_pkg::len_t      length;
        eth_ctrl_pkg::gen_mode_t  mode;
        logic                     extra_start;  // Second start while busy
    } row_t;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     wr_en;
    eth_frame_pkg::buf_addr_t wr_addr;
    eth_frame_pkg::byte_t     wr_data;
    logic                     start;
    eth_frame_pkg::mac_addr_t dest;
    eth_frame_pkg::mac_addr_t src;
    eth_frame_pkg::len_t      length;
    eth_ctrl_pkg::gen_mode_t  mode;
    eth_frame_pkg::byte_t     tx_data;
    logic                     tx_valid;
    logic                     tx_last;
    logic                     busy;
    logic                     done;
    int                       chk_errors;
    int                       frames_seen;
    int                       bench_errors = 0;
    logic [31:0]              lcg_state = 32'd14;
    row_t                     rows [NUM_ROWS];

    always #5 clk = ~clk;

    mac_tx_top mac_tx_top_inst (
        .clk (clk), .i_rst_n (rst_n),
        .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
        .i_start (start), .i_dest_addr (dest), .i_src_addr (src),
        .i_length (length), .i_mode (mode),
        .o_tx_data (tx_data), .o_tx_valid (tx_valid), .o_tx_last (tx_last),
        .o_busy (busy), .o_done (done)
    );

    tb_frame_checker frame_checker_inst (
        .clk (clk), .i_rst_n (rst_n),
        .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
        .i_start (start), .i_dest_addr (dest), .i_src_addr (src),
        .i_length (length), .i_mode (mode),
        .i_tx_data (tx_data), .i_tx_valid (tx_valid), .i_tx_last (tx_last),
        .i_busy (busy), .i_done (done),
        .o_error_count (chk_errors), .o_frame_count (frames_seen)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_payload(input eth_frame_pkg::len_t count);
        for (int i = 0; i < int'(count); i++) begin
            lcg_state = lcg_next(lcg_state);
            wr_en   = 1'b1;
            wr_addr = eth_frame_pkg::buf_addr_t'(i);
            wr_data = lcg_state[23:16];
            step();
        end
        wr_en = 1'b0;
    endtask

    task automatic pulse_start(input row_t r);
        dest   = r.dest;
        src    = r.src;
        length = r.length;
        mode   = r.mode;
        start  = 1'b1;
        step();
        start  = 1'b0;
    endtask

    initial begin
        int   waited;
        logic timed_out;
        rows[0] = '{48'hFFFFFFFFFFFF, 48'h02005E102030, 16'd100, eth_ctrl_pkg::MODE_NORMAL, 1'b1};
        rows[1] = '{48'h0A1B2C3D4E5F, 48'h001122334455, 16'd10, eth_ctrl_pkg::MODE_NORMAL, 1'b0};
        rows[2] = '{48'h112233445566, 48'hA0B0C0D0E0F0, 16'd0, eth_ctrl_pkg::MODE_NO_PAD, 1'b0};
        rows[3] = '{48'h8899AABBCCDD, 48'h0F0E0D0C0B0A, 16'd5, eth_ctrl_pkg::MODE_NO_PAD, 1'b0};
        rows[4] = '{48'h0123456789AB, 48'hCDEF01234567, 16'd20, eth_ctrl_pkg::MODE_FIXED, 1'b0};
        rows[5] = '{48'h5A5A5A5A5A5A, 48'hA5A5A5A5A5A5, 16'd46, eth_ctrl_pkg::MODE_NORMAL, 1'b0};
        timed_out = 1'b0;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        start   = 1'b0;
        dest    = '0;
        src     = '0;
        length  = '0;
        mode    = eth_ctrl_pkg::MODE_NORMAL;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            load_payload(rows[r].length);
            pulse_start(rows[r]);
            if (rows[r].extra_start) begin
                repeat (3) step();
                pulse_start(rows[r]);  // DUT is busy, so this start is dropped
            end
            waited = 0;
            while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
                step();
                waited++;
            end
            if (done !== 1'b1) begin
                timed_out = 1'b1;
                bench_errors++;
                $display("Timed out waiting for o_done on row %0d", r);
            end
            step();
        end
        repeat (4) step();  // Bus stays quiet after the last frame
        if (!timed_out && frames_seen != NUM_ROWS) begin
            bench_errors++;
            $display("Saw %0d frames but expected %0d", frames_seen, NUM_ROWS);
        end
        $display("Errors: checker %0d, bench %0d", chk_errors, bench_errors);
        if (chk_errors == 0 && bench_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/eth_frame_pkg.sv
hw/eth_ctrl_pkg.sv
hw/crc_if.sv
hw/crc32_byte.sv
hw/payload_buffer.sv
hw/mac_frame_generator.sv
hw/mac_tx_top.sv
bench/tb_frame_checker.sv
bench/tb_mac_tx.sv

/* Makefile */
# Verilator build and run for the Ethernet frame transmitter

VERILATOR = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_mac_tx
FILELIST  = sim.f
BUILD     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD)
